// ==== src/vfdsu_pkg.sv ====
// ==========================================================
// VFDSU EX2 shared definitions: formats, widths, exponent
// limits and the vector types passed between the stages
// ==========================================================
`default_nettype none

package vfdsu_pkg;

  // Field widths
  localparam int EXPNT_W     = 13;
  localparam int SIG_W       = 53;
  localparam int DOUB_FRAC_W = 52;
  localparam int SING_FRAC_W = 23;
  localparam int HALF_FRAC_W = 10;

  // Low exponent bits examined for single and half
  localparam int SING_FLD_W  = 10;
  localparam int HALF_FLD_W  = 7;

  // Minimum normal exponent per format
  localparam int DOUB_EMIN   = -1022;
  localparam int SING_EMIN   = -126;
  localparam int HALF_EMIN   = -14;

  // Quotient exponent at which overflow becomes possible
  localparam int DOUB_OF_LIM = 1024;
  localparam int SING_OF_LIM = 128;
  localparam int HALF_OF_LIM = 16;

  // Vector types
  typedef logic signed [EXPNT_W-1:0] expnt_t;
  typedef logic        [1:0]         fmt_t;
  typedef logic        [SIG_W-1:0]   round_add_t;
  typedef logic        [DOUB_FRAC_W-1:0] frac_t;
  typedef logic        [2:0]         rm_t;

  // Format codes, half is the default
  localparam fmt_t FMT_HALF   = 2'd0;
  localparam fmt_t FMT_SINGLE = 2'd1;
  localparam fmt_t FMT_DOUBLE = 2'd2;

endpackage

`default_nettype wire

// ==== src/vfdsu_if.sv ====
// ==========================================================
// EX2 bundles: result exponent with its qualifiers, and the
// range flags with the denormal rounding increment
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

// Exponent and operand qualifiers from the exponent stage
interface vfdsu_expnt_if;
  vfdsu_pkg::expnt_t expnt_rst;
  vfdsu_pkg::fmt_t   fmt;
  logic              op0_norm;
  logic              op1_norm;
  logic              div;

  modport src (output expnt_rst, fmt, op0_norm, op1_norm, div);
  modport dst (input  expnt_rst, fmt, op0_norm, op1_norm, div);
endinterface

// Range flags and rounding increment toward EX3
interface vfdsu_flags_if;
  logic                  of;
  logic                  uf;
  logic                  potnt_of;
  logic                  potnt_uf;
  logic                  id_srt_skip;
  logic                  rslt_denorm;
  logic                  result_inf;
  logic                  result_lfn;
  vfdsu_pkg::round_add_t round_add;

  // Range stage owns every flag except the increment
  modport src (output of, uf, potnt_of, potnt_uf, id_srt_skip,
               rslt_denorm, result_inf, result_lfn);
  // Denormal table owns the increment
  modport tbl (output round_add);
  modport dst (input  of, uf, potnt_of, potnt_uf, id_srt_skip,
               rslt_denorm, result_inf, result_lfn, round_add);
endinterface

`default_nettype wire

// ==== src/vfdsu_expnt_calc.sv ====
// ==========================================================
// EX2 result exponent for divide or square root
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module vfdsu_expnt_calc (
  input  vfdsu_pkg::expnt_t expnt_add0,
  input  vfdsu_pkg::expnt_t expnt_add1,
  input  logic              sqrt,
  input  logic              double,
  input  logic              single,
  input  logic              op0_norm,
  input  logic              op1_norm,
  input  logic              div,
  vfdsu_expnt_if.src        expnt
);

  vfdsu_pkg::expnt_t expnt_diff;
  vfdsu_pkg::expnt_t sqrt_expnt;

  // Biased exponents cancel in the difference, wraps mod 2^13
  assign expnt_diff = expnt_add0 - expnt_add1;

  // Square root halves the exponent, sign kept
  assign sqrt_expnt = {expnt_diff[vfdsu_pkg::EXPNT_W-1],
                       expnt_diff[vfdsu_pkg::EXPNT_W-1:1]};

  assign expnt.expnt_rst = sqrt ? sqrt_expnt : expnt_diff;

  // Format encode, double wins over single
  assign expnt.fmt = double ? vfdsu_pkg::FMT_DOUBLE :
                     single ? vfdsu_pkg::FMT_SINGLE :
                              vfdsu_pkg::FMT_HALF;

  assign expnt.op0_norm = op0_norm;
  assign expnt.op1_norm = op1_norm;
  assign expnt.div      = div;

endmodule

`default_nettype wire

// ==== src/vfdsu_expnt_range.sv ====
// ==========================================================
// EX2 exponent range checks per format, iteration skip and
// the merge of overflow into the special results
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module vfdsu_expnt_range (
  vfdsu_expnt_if.dst  expnt,
  input  logic        result_inf_in,
  input  logic        of_rm_lfn,
  input  logic        srt_skip,
  vfdsu_flags_if.src  flags,
  output logic        srt_ctrl_skip_srt
);

  // Low exponent fields seen by the narrow formats
  logic signed [vfdsu_pkg::SING_FLD_W-1:0] sing_fld;
  logic signed [vfdsu_pkg::HALF_FLD_W-1:0] half_fld;

  // Selected field and limits of the active format
  vfdsu_pkg::expnt_t fld;
  vfdsu_pkg::expnt_t of_lim;
  vfdsu_pkg::expnt_t emin;
  vfdsu_pkg::expnt_t uf_lim;
  vfdsu_pkg::expnt_t skip_lim;

  logic of_pre;
  logic potnt_of_pre;
  logic uf_pre;
  logic potnt_uf_pre;
  logic skip_pre;
  logic both_norm_div;
  logic of_ex2;

  assign sing_fld = expnt.expnt_rst[vfdsu_pkg::SING_FLD_W-1:0];
  assign half_fld = expnt.expnt_rst[vfdsu_pkg::HALF_FLD_W-1:0];

  // ========================================================
  // Format selection
  // ========================================================
  always_comb
  begin
    case (expnt.fmt)
      vfdsu_pkg::FMT_DOUBLE:
      begin
        fld      = expnt.expnt_rst;
        of_lim   = vfdsu_pkg::expnt_t'(vfdsu_pkg::DOUB_OF_LIM);
        emin     = vfdsu_pkg::expnt_t'(vfdsu_pkg::DOUB_EMIN);
        skip_lim = vfdsu_pkg::expnt_t'(vfdsu_pkg::DOUB_EMIN - vfdsu_pkg::DOUB_FRAC_W - 1);
      end
      vfdsu_pkg::FMT_SINGLE:
      begin
        fld      = sing_fld;
        of_lim   = vfdsu_pkg::expnt_t'(vfdsu_pkg::SING_OF_LIM);
        emin     = vfdsu_pkg::expnt_t'(vfdsu_pkg::SING_EMIN);
        skip_lim = vfdsu_pkg::expnt_t'(vfdsu_pkg::SING_EMIN - vfdsu_pkg::SING_FRAC_W - 1);
      end
      default:
      begin
        fld      = half_fld;
        of_lim   = vfdsu_pkg::expnt_t'(vfdsu_pkg::HALF_OF_LIM);
        emin     = vfdsu_pkg::expnt_t'(vfdsu_pkg::HALF_EMIN);
        skip_lim = vfdsu_pkg::expnt_t'(vfdsu_pkg::HALF_EMIN - vfdsu_pkg::HALF_FRAC_W - 1);
      end
    endcase
  end

  // Result is denormal one step below emin
  assign uf_lim = emin - vfdsu_pkg::expnt_t'(1);

  // ========================================================
  // Raw range checks
  // ========================================================
  assign of_pre       = (fld > of_lim);
  assign potnt_of_pre = (fld == of_lim);
  // Underflow and skip look at the full exponent
  assign uf_pre       = (expnt.expnt_rst <= uf_lim);
  assign potnt_uf_pre = (fld == emin);
  // Quotient lies below half the smallest denormal
  assign skip_pre     = (expnt.expnt_rst < skip_lim);

  // Range only meaningful for a divide of two normals
  assign both_norm_div = expnt.op0_norm & expnt.op1_norm & expnt.div;
  assign of_ex2        = of_pre & both_norm_div;

  assign flags.of          = of_ex2;
  assign flags.potnt_of    = potnt_of_pre & both_norm_div;
  assign flags.uf          = uf_pre & both_norm_div;
  assign flags.rslt_denorm = uf_pre & both_norm_div;
  assign flags.potnt_uf    = potnt_uf_pre & expnt.op0_norm;
  assign flags.id_srt_skip = skip_pre;

  // ========================================================
  // Special results
  // ========================================================
  // Overflow rounds to infinity or largest finite by rm
  assign flags.result_inf = result_inf_in | (of_ex2 & ~of_rm_lfn);
  assign flags.result_lfn = of_ex2 & of_rm_lfn;

  assign srt_ctrl_skip_srt = of_ex2 | skip_pre | srt_skip;

endmodule

`default_nettype wire

// ==== src/vfdsu_denorm_round_table.sv ====
// ==========================================================
// One-hot denormal rounding increment from exponent and format
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module vfdsu_denorm_round_table (
  vfdsu_expnt_if.dst  expnt,
  vfdsu_flags_if.tbl  flags
);

  // Two extra bits cover emin minus the most positive exponent
  logic signed [vfdsu_pkg::EXPNT_W+1:0] lo_pos;
  logic signed [vfdsu_pkg::EXPNT_W+1:0] emin;
  logic signed [vfdsu_pkg::EXPNT_W+1:0] idx;
  logic                                 in_range;

  // ========================================================
  // Lowest fraction position and emin of the format
  // ========================================================
  always_comb
  begin
    case (expnt.fmt)
      vfdsu_pkg::FMT_DOUBLE:
      begin
        lo_pos = 15'(vfdsu_pkg::SIG_W - 1 - vfdsu_pkg::DOUB_FRAC_W);
        emin   = 15'(vfdsu_pkg::DOUB_EMIN);
      end
      vfdsu_pkg::FMT_SINGLE:
      begin
        lo_pos = 15'(vfdsu_pkg::SIG_W - 1 - vfdsu_pkg::SING_FRAC_W);
        emin   = 15'(vfdsu_pkg::SING_EMIN);
      end
      default:
      begin
        lo_pos = 15'(vfdsu_pkg::SIG_W - 1 - vfdsu_pkg::HALF_FRAC_W);
        emin   = 15'(vfdsu_pkg::HALF_EMIN);
      end
    endcase
  end

  // Each step below emin moves the increment one bit up
  assign idx = lo_pos + emin - expnt.expnt_rst;

  // Past bit 52 the increment falls off the significand
  assign in_range = (idx >= lo_pos) && (idx <= 15'(vfdsu_pkg::SIG_W - 1));

  assign flags.round_add = in_range ?
                           (vfdsu_pkg::round_add_t'(1) << idx[5:0]) :
                           '0;

endmodule

`default_nettype wire

// ==== src/vfdsu_ex3_pipe.sv ====
// ==========================================================
// EX3 pipeline register, loads on pipedown, holds otherwise
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module vfdsu_ex3_pipe (
  input  logic                  ex2_pipe_clk,
  input  logic                  cpurst_b,
  input  logic                  pipedown,
  vfdsu_flags_if.dst            flags,
  vfdsu_expnt_if.dst            expnt,
  input  logic                  result_zero_in,
  input  logic                  result_qnan_in,
  input  logic                  nv_in,
  input  logic                  dz_in,
  input  logic                  result_sign_in,
  input  logic                  qnan_sign_in,
  input  vfdsu_pkg::frac_t      qnan_f_in,
  input  vfdsu_pkg::rm_t        rm_in,
  output logic                  ex3_of,
  output logic                  ex3_uf,
  output logic                  ex3_potnt_of,
  output logic                  ex3_potnt_uf,
  output logic                  ex3_id_srt_skip,
  output logic                  ex3_rslt_denorm,
  output logic                  ex3_result_inf,
  output logic                  ex3_result_lfn,
  output vfdsu_pkg::round_add_t ex3_round_add,
  output vfdsu_pkg::expnt_t     ex3_expnt_rst,
  output vfdsu_pkg::fmt_t       ex3_fmt,
  output logic                  ex3_result_zero,
  output logic                  ex3_result_qnan,
  output logic                  ex3_nv,
  output logic                  ex3_dz,
  output logic                  ex3_result_sign,
  output logic                  ex3_qnan_sign,
  output vfdsu_pkg::frac_t      ex3_qnan_f,
  output vfdsu_pkg::rm_t        ex3_rm
);

  always_ff @(posedge ex2_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ex3_of          <= 1'b0;
      ex3_uf          <= 1'b0;
      ex3_potnt_of    <= 1'b0;
      ex3_potnt_uf    <= 1'b0;
      ex3_id_srt_skip <= 1'b0;
      ex3_rslt_denorm <= 1'b0;
      ex3_result_inf  <= 1'b0;
      ex3_result_lfn  <= 1'b0;
      ex3_round_add   <= '0;
      ex3_expnt_rst   <= '0;
      ex3_fmt         <= '0;
      ex3_result_zero <= 1'b0;
      ex3_result_qnan <= 1'b0;
      ex3_nv          <= 1'b0;
      ex3_dz          <= 1'b0;
      ex3_result_sign <= 1'b0;
      ex3_qnan_sign   <= 1'b0;
      ex3_qnan_f      <= '0;
      ex3_rm          <= '0;
    end
    else if (pipedown)
    begin
      // Range flags and increment
      ex3_of          <= flags.of;
      ex3_uf          <= flags.uf;
      ex3_potnt_of    <= flags.potnt_of;
      ex3_potnt_uf    <= flags.potnt_uf;
      ex3_id_srt_skip <= flags.id_srt_skip;
      ex3_rslt_denorm <= flags.rslt_denorm;
      ex3_result_inf  <= flags.result_inf;
      ex3_result_lfn  <= flags.result_lfn;
      ex3_round_add   <= flags.round_add;
      // Single exponent copy for EX3
      ex3_expnt_rst   <= expnt.expnt_rst;
      ex3_fmt         <= expnt.fmt;
      // Special result info from EX1
      ex3_result_zero <= result_zero_in;
      ex3_result_qnan <= result_qnan_in;
      ex3_nv          <= nv_in;
      ex3_dz          <= dz_in;
      ex3_result_sign <= result_sign_in;
      ex3_qnan_sign   <= qnan_sign_in;
      ex3_qnan_f      <= qnan_f_in;
      ex3_rm          <= rm_in;
    end
  end

endmodule

`default_nettype wire

// ==== src/vfdsu_ex2_stage.sv ====
// ==========================================================
// VFDSU EX2 stage top: exponent, range and denormal table
// feeding the EX3 register
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module vfdsu_ex2_stage (
  input  logic                  ex2_pipe_clk,
  input  logic                  cpurst_b,
  input  logic                  pipedown,
  input  vfdsu_pkg::expnt_t     expnt_add0,
  input  vfdsu_pkg::expnt_t     expnt_add1,
  input  logic                  sqrt,
  input  logic                  div,
  input  logic                  double,
  input  logic                  single,
  input  logic                  op0_norm,
  input  logic                  op1_norm,
  input  logic                  result_inf,
  input  logic                  of_rm_lfn,
  input  logic                  srt_skip,
  input  logic                  result_zero,
  input  logic                  result_qnan,
  input  logic                  nv,
  input  logic                  dz,
  input  logic                  result_sign,
  input  logic                  qnan_sign,
  input  vfdsu_pkg::frac_t      qnan_f,
  input  vfdsu_pkg::rm_t        rm,
  output logic                  srt_ctrl_skip_srt,
  output logic                  ex3_of,
  output logic                  ex3_uf,
  output logic                  ex3_potnt_of,
  output logic                  ex3_potnt_uf,
  output logic                  ex3_id_srt_skip,
  output logic                  ex3_rslt_denorm,
  output logic                  ex3_result_inf,
  output logic                  ex3_result_lfn,
  output vfdsu_pkg::round_add_t ex3_round_add,
  output vfdsu_pkg::expnt_t     ex3_expnt_rst,
  output vfdsu_pkg::fmt_t       ex3_fmt,
  output logic                  ex3_result_zero,
  output logic                  ex3_result_qnan,
  output logic                  ex3_nv,
  output logic                  ex3_dz,
  output logic                  ex3_result_sign,
  output logic                  ex3_qnan_sign,
  output vfdsu_pkg::frac_t      ex3_qnan_f,
  output vfdsu_pkg::rm_t        ex3_rm
);

  vfdsu_expnt_if u_expnt_if ();
  vfdsu_flags_if u_flags_if ();

  // ========================================================
  // EX2 combinational stages
  // ========================================================
  vfdsu_expnt_calc u_expnt_calc (
    .expnt_add0 (expnt_add0),
    .expnt_add1 (expnt_add1),
    .sqrt       (sqrt),
    .double     (double),
    .single     (single),
    .op0_norm   (op0_norm),
    .op1_norm   (op1_norm),
    .div        (div),
    .expnt      (u_expnt_if.src)
  );

  vfdsu_expnt_range u_expnt_range (
    .expnt             (u_expnt_if.dst),
    .result_inf_in     (result_inf),
    .of_rm_lfn         (of_rm_lfn),
    .srt_skip          (srt_skip),
    .flags             (u_flags_if.src),
    .srt_ctrl_skip_srt (srt_ctrl_skip_srt)
  );

  vfdsu_denorm_round_table u_denorm_round_table (
    .expnt (u_expnt_if.dst),
    .flags (u_flags_if.tbl)
  );

  // ========================================================
  // EX3 register
  // ========================================================
  vfdsu_ex3_pipe u_ex3_pipe (
    .ex2_pipe_clk    (ex2_pipe_clk),
    .cpurst_b        (cpurst_b),
    .pipedown        (pipedown),
    .flags           (u_flags_if.dst),
    .expnt           (u_expnt_if.dst),
    .result_zero_in  (result_zero),
    .result_qnan_in  (result_qnan),
    .nv_in           (nv),
    .dz_in           (dz),
    .result_sign_in  (result_sign),
    .qnan_sign_in    (qnan_sign),
    .qnan_f_in       (qnan_f),
    .rm_in           (rm),
    .ex3_of          (ex3_of),
    .ex3_uf          (ex3_uf),
    .ex3_potnt_of    (ex3_potnt_of),
    .ex3_potnt_uf    (ex3_potnt_uf),
    .ex3_id_srt_skip (ex3_id_srt_skip),
    .ex3_rslt_denorm (ex3_rslt_denorm),
    .ex3_result_inf  (ex3_result_inf),
    .ex3_result_lfn  (ex3_result_lfn),
    .ex3_round_add   (ex3_round_add),
    .ex3_expnt_rst   (ex3_expnt_rst),
    .ex3_fmt         (ex3_fmt),
    .ex3_result_zero (ex3_result_zero),
    .ex3_result_qnan (ex3_result_qnan),
    .ex3_nv          (ex3_nv),
    .ex3_dz          (ex3_dz),
    .ex3_result_sign (ex3_result_sign),
    .ex3_qnan_sign   (ex3_qnan_sign),
    .ex3_qnan_f      (ex3_qnan_f),
    .ex3_rm          (ex3_rm)
  );

endmodule

`default_nettype wire

// ==== bench/tb_vfdsu_tasks.svh ====
// ==========================================================
// Directed EX2 tests, vector driver and xorshift source
// ==========================================================
`ifndef TB_VFDSU_TASKS_SVH
`define TB_VFDSU_TASKS_SVH

function automatic logic [31:0] xorshift(input logic [31:0] x);
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function logic [31:0] next_rand();
  rng_state = xorshift(rng_state);
  return rng_state;
endfunction

// Waits at falling edges until EX3 has loaded past start
task automatic wait_capture(input string tname, input int start);
  int tmo;
  tmo = 0;
  while (cap_count == start && tmo < WAIT_LIMIT)
  begin
    @(negedge ex2_pipe_clk);
    tmo++;
  end
  if (cap_count == start)
  begin
    errors++;
    $display("timeout in %s: EX3 never loaded the vector", tname);
  end
endtask

// ==========================================================
// One vector through EX2 and EX3, all outputs checked
// ==========================================================
task automatic run_vec(
  input string             tname,
  input vfdsu_pkg::expnt_t a0,
  input vfdsu_pkg::expnt_t a1,
  input logic              sq,
  input logic              dv,
  input logic              dbl,
  input logic              sgl,
  input logic              n0,
  input logic              n1,
  input logic              rinf,
  input logic              lfn,
  input logic              sskip
);
  vfdsu_pkg::expnt_t e;
  vfdsu_pkg::fmt_t   f;
  int                fld;
  int                start;
  logic              nd;
  logic              of_e;
  logic              pof_e;
  logic              uf_e;
  logic              puf_e;
  logic              skip_e;
  logic [31:0]       r0;
  logic [31:0]       r1;
  logic [60:0]       pass_e;
  e      = ref_expnt(a0, a1, sq);
  f      = ref_fmt(dbl, sgl);
  fld    = fld_val(e, f);
  nd     = dv & n0 & n1;
  of_e   = nd & (fld > of_lim(f));
  pof_e  = nd & (fld == of_lim(f));
  uf_e   = nd & (int'(e) <= emin_of(f) - 1);
  puf_e  = n0 & (fld == emin_of(f));
  skip_e = (int'(e) < skip_bnd(f));
  r0     = next_rand();
  r1     = next_rand();
  // zero, qnan, nv, dz, signs, qnan fraction, rounding mode
  pass_e = {r1[25:20], r1[19:0], r0, r1[28:26]};
  vectors++;
  @(posedge ex2_pipe_clk);
  expnt_add0 <= a0;
  expnt_add1 <= a1;
  sqrt       <= sq;
  div        <= dv;
  double     <= dbl;
  single     <= sgl;
  op0_norm   <= n0;
  op1_norm   <= n1;
  result_inf <= rinf;
  of_rm_lfn  <= lfn;
  srt_skip   <= sskip;
  {result_zero, result_qnan, nv, dz, result_sign, qnan_sign, qnan_f, rm} <= pass_e;
  pipedown   <= 1'b1;
  @(negedge ex2_pipe_clk);
  if (srt_ctrl_skip_srt !== (of_e | skip_e | sskip))
    report_mismatch(tname, "skip_srt", of_e | skip_e | sskip, srt_ctrl_skip_srt);
  start = cap_count;
  // Single load edge, EX3 holds afterwards
  @(posedge ex2_pipe_clk);
  pipedown <= 1'b0;
  wait_capture(tname, start);
  if (ex3_expnt_rst !== e)
    report_mismatch(tname, "expnt_rst", e, ex3_expnt_rst);
  if (ex3_fmt !== f)
    report_mismatch(tname, "fmt", f, ex3_fmt);
  if (ex3_of !== of_e)
    report_mismatch(tname, "of", of_e, ex3_of);
  if (ex3_potnt_of !== pof_e)
    report_mismatch(tname, "potnt_of", pof_e, ex3_potnt_of);
  if (ex3_uf !== uf_e)
    report_mismatch(tname, "uf", uf_e, ex3_uf);
  if (ex3_rslt_denorm !== uf_e)
    report_mismatch(tname, "rslt_denorm", uf_e, ex3_rslt_denorm);
  if (ex3_potnt_uf !== puf_e)
    report_mismatch(tname, "potnt_uf", puf_e, ex3_potnt_uf);
  if (ex3_id_srt_skip !== skip_e)
    report_mismatch(tname, "id_srt_skip", skip_e, ex3_id_srt_skip);
  if (ex3_result_inf !== (rinf | (of_e & ~lfn)))
    report_mismatch(tname, "result_inf", rinf | (of_e & ~lfn), ex3_result_inf);
  if (ex3_result_lfn !== (of_e & lfn))
    report_mismatch(tname, "result_lfn", of_e & lfn, ex3_result_lfn);
  if (ex3_round_add !== ref_round_add(e, f))
    report_mismatch(tname, "round_add", ref_round_add(e, f), ex3_round_add);
  if ({ex3_result_zero, ex3_result_qnan, ex3_nv, ex3_dz, ex3_result_sign,
       ex3_qnan_sign, ex3_qnan_f, ex3_rm} !== pass_e)
    report_mismatch(tname, "pass-through", pass_e,
                    {ex3_result_zero, ex3_result_qnan, ex3_nv, ex3_dz,
                     ex3_result_sign, ex3_qnan_sign, ex3_qnan_f, ex3_rm});
endtask

// Divide with add1 at zero so the result exponent is e
task automatic run_at(input string tname, input int e, input logic dbl, input logic sgl,
                      input logic n0, input logic n1, input logic dv, input logic lfn);
  run_vec(tname, to_expnt(e), '0, 1'b0, dv, dbl, sgl, n0, n1, 1'b0, lfn, 1'b0);
endtask

// ==========================================================
// Directed tests
// ==========================================================
task automatic test_exponent();
  logic [31:0] r;
  logic [31:0] s;
  for (int i = 0; i < 24; i++)
  begin
    r = next_rand();
    s = next_rand();
    run_vec("exponent", r[12:0], s[12:0], i[0], ~i[0], s[13], s[14],
            1'b1, 1'b1, s[15], s[16], s[17]);
  end
endtask

task automatic test_overflow();
  logic dbl;
  logic sgl;
  int   lim;
  int   wrap;
  for (int k = 0; k < 3; k++)
  begin
    dbl  = (k == 2);
    sgl  = (k == 1);
    lim  = of_lim(ref_fmt(dbl, sgl));
    // Upper bits outside the narrow field must not matter
    wrap = (k == 1) ? 1024 : ((k == 0) ? 128 : 0);
    for (int d = -1; d <= 1; d++)
      run_at("overflow", lim + d, dbl, sgl, 1'b1, 1'b1, 1'b1, 1'b0);
    run_at("overflow", lim + 1, dbl, sgl, 1'b1, 1'b1, 1'b1, 1'b1);
    run_at("overflow", lim + 1, dbl, sgl, 1'b0, 1'b1, 1'b1, 1'b0);
    run_at("overflow", lim + 1, dbl, sgl, 1'b1, 1'b0, 1'b1, 1'b0);
    run_at("overflow", lim + 1, dbl, sgl, 1'b1, 1'b1, 1'b0, 1'b0);
    run_at("overflow", lim + 1 - wrap, dbl, sgl, 1'b1, 1'b1, 1'b1, 1'b1);
    run_vec("overflow", to_expnt(lim), '0, 1'b0, 1'b1, dbl, sgl,
            1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
  end
endtask

task automatic test_underflow();
  logic dbl;
  logic sgl;
  int   em;
  int   sb;
  int   wrap;
  for (int k = 0; k < 3; k++)
  begin
    dbl  = (k == 2);
    sgl  = (k == 1);
    em   = emin_of(ref_fmt(dbl, sgl));
    sb   = skip_bnd(ref_fmt(dbl, sgl));
    wrap = (k == 1) ? 1024 : ((k == 0) ? 128 : 0);
    for (int d = -1; d <= 1; d++)
    begin
      run_at("underflow", em + d, dbl, sgl, 1'b1, 1'b1, 1'b1, 1'b0);
      run_at("skip", sb + d, dbl, sgl, 1'b1, 1'b1, 1'b1, 1'b0);
    end
    run_at("underflow", em - 1, dbl, sgl, 1'b1, 1'b1, 1'b0, 1'b0);
    run_at("underflow", em - 1, dbl, sgl, 1'b0, 1'b1, 1'b1, 1'b0);
    run_at("underflow", em - 1, dbl, sgl, 1'b1, 1'b0, 1'b1, 1'b0);
    run_at("underflow", em, dbl, sgl, 1'b0, 1'b1, 1'b1, 1'b0);
    run_at("underflow", em, dbl, sgl, 1'b1, 1'b0, 1'b1, 1'b0);
    // Potential underflow looks at the narrow field only
    run_at("underflow", em + wrap, dbl, sgl, 1'b1, 1'b1, 1'b1, 1'b0);
  end
  run_vec("skip", '0, '0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
endtask

// Sweeps past both ends of each format's table
task automatic test_denorm();
  logic dbl;
  logic sgl;
  int   em;
  int   fw;
  for (int k = 0; k < 3; k++)
  begin
    dbl = (k == 2);
    sgl = (k == 1);
    em  = emin_of(ref_fmt(dbl, sgl));
    fw  = frac_w(ref_fmt(dbl, sgl));
    for (int e = em + 1; e >= em - fw - 2; e--)
      run_at("denorm", e, dbl, sgl, 1'b1, 1'b1, 1'b1, 1'b0);
  end
endtask

function automatic logic [191:0] out_snapshot();
  return {ex3_of, ex3_uf, ex3_potnt_of, ex3_potnt_uf, ex3_id_srt_skip,
          ex3_rslt_denorm, ex3_result_inf, ex3_result_lfn, ex3_round_add,
          ex3_expnt_rst, ex3_fmt, ex3_result_zero, ex3_result_qnan, ex3_nv,
          ex3_dz, ex3_result_sign, ex3_qnan_sign, ex3_qnan_f, ex3_rm};
endfunction

task automatic test_hold_reset();
  logic [191:0] snap;
  run_at("hold", 1025, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
  @(negedge ex2_pipe_clk);
  snap = out_snapshot();
  // Half at -112 would set potnt_of, uf and skip if EX3 loaded
  @(posedge ex2_pipe_clk);
  expnt_add0 <= to_expnt(-112);
  expnt_add1 <= '0;
  double     <= 1'b0;
  single     <= 1'b0;
  result_inf <= ~result_inf;
  {result_zero, result_qnan, nv, dz, result_sign, qnan_sign} <=
    ~{result_zero, result_qnan, nv, dz, result_sign, qnan_sign};
  qnan_f     <= ~qnan_f;
  rm         <= ~rm;
  repeat (3) @(negedge ex2_pipe_clk);
  if (out_snapshot() !== snap)
    report_mismatch("hold", "ex3 outputs", snap, out_snapshot());
  @(posedge ex2_pipe_clk);
  cpurst_b <= 1'b0;
  @(negedge ex2_pipe_clk);
  if (out_snapshot() !== '0)
    report_mismatch("reset", "ex3 outputs", '0, out_snapshot());
  @(posedge ex2_pipe_clk);
  cpurst_b <= 1'b1;
  run_at("after_reset", -1030, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0);
endtask

`endif

// ==== bench/tb_vfdsu_ex2_stage.sv ====
// ==========================================================
// VFDSU EX2 stage testbench: clock, reset, reference rules,
// directed test sequence and final report
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module tb_vfdsu_ex2_stage;

  localparam int WAIT_LIMIT = 8;

  logic                  ex2_pipe_clk;
  logic                  cpurst_b;
  logic                  pipedown;
  vfdsu_pkg::expnt_t     expnt_add0;
  vfdsu_pkg::expnt_t     expnt_add1;
  logic                  sqrt;
  logic                  div;
  logic                  double;
  logic                  single;
  logic                  op0_norm;
  logic                  op1_norm;
  logic                  result_inf;
  logic                  of_rm_lfn;
  logic                  srt_skip;
  logic                  result_zero;
  logic                  result_qnan;
  logic                  nv;
  logic                  dz;
  logic                  result_sign;
  logic                  qnan_sign;
  vfdsu_pkg::frac_t      qnan_f;
  vfdsu_pkg::rm_t        rm;
  logic                  srt_ctrl_skip_srt;
  logic                  ex3_of;
  logic                  ex3_uf;
  logic                  ex3_potnt_of;
  logic                  ex3_potnt_uf;
  logic                  ex3_id_srt_skip;
  logic                  ex3_rslt_denorm;
  logic                  ex3_result_inf;
  logic                  ex3_result_lfn;
  vfdsu_pkg::round_add_t ex3_round_add;
  vfdsu_pkg::expnt_t     ex3_expnt_rst;
  vfdsu_pkg::fmt_t       ex3_fmt;
  logic                  ex3_result_zero;
  logic                  ex3_result_qnan;
  logic                  ex3_nv;
  logic                  ex3_dz;
  logic                  ex3_result_sign;
  logic                  ex3_qnan_sign;
  vfdsu_pkg::frac_t      ex3_qnan_f;
  vfdsu_pkg::rm_t        ex3_rm;

  int          errors    = 0;
  int          vectors   = 0;
  int          cap_count = 0;
  logic [31:0] rng_state = 32'h5080_848a;

  vfdsu_ex2_stage uut (.*);

  always #5 ex2_pipe_clk = ~ex2_pipe_clk;

  // Counts the edges where EX3 loads
  always @(posedge ex2_pipe_clk)
  begin
    if (cpurst_b && pipedown)
      cap_count <= cap_count + 1;
  end

  // ========================================================
  // Reference rules
  // ========================================================
  function automatic vfdsu_pkg::expnt_t to_expnt(input int v);
    return vfdsu_pkg::expnt_t'(v);
  endfunction

  function automatic vfdsu_pkg::expnt_t ref_expnt(input vfdsu_pkg::expnt_t a0,
                                                  input vfdsu_pkg::expnt_t a1,
                                                  input logic sq);
    vfdsu_pkg::expnt_t d;
    d = a0 - a1;
    return sq ? (d >>> 1) : d;
  endfunction

  function automatic vfdsu_pkg::fmt_t ref_fmt(input logic dbl, input logic sgl);
    if (dbl)
      return vfdsu_pkg::FMT_DOUBLE;
    if (sgl)
      return vfdsu_pkg::FMT_SINGLE;
    return vfdsu_pkg::FMT_HALF;
  endfunction

  // Signed value of the exponent field the format looks at
  function automatic int fld_val(input vfdsu_pkg::expnt_t e, input vfdsu_pkg::fmt_t f);
    case (f)
      vfdsu_pkg::FMT_DOUBLE: return int'(e);
      vfdsu_pkg::FMT_SINGLE: return int'($signed(e[9:0]));
      default:               return int'($signed(e[6:0]));
    endcase
  endfunction

  function automatic int of_lim(input vfdsu_pkg::fmt_t f);
    case (f)
      vfdsu_pkg::FMT_DOUBLE: return 1024;
      vfdsu_pkg::FMT_SINGLE: return 128;
      default:               return 16;
    endcase
  endfunction

  function automatic int emin_of(input vfdsu_pkg::fmt_t f);
    case (f)
      vfdsu_pkg::FMT_DOUBLE: return -1022;
      vfdsu_pkg::FMT_SINGLE: return -126;
      default:               return -14;
    endcase
  endfunction

  function automatic int frac_w(input vfdsu_pkg::fmt_t f);
    case (f)
      vfdsu_pkg::FMT_DOUBLE: return 52;
      vfdsu_pkg::FMT_SINGLE: return 23;
      default:               return 10;
    endcase
  endfunction

  // Below this exponent the iteration is skipped
  function automatic int skip_bnd(input vfdsu_pkg::fmt_t f);
    case (f)
      vfdsu_pkg::FMT_DOUBLE: return -1075;
      vfdsu_pkg::FMT_SINGLE: return -150;
      default:               return -25;
    endcase
  endfunction

  function automatic vfdsu_pkg::round_add_t ref_round_add(input vfdsu_pkg::expnt_t e,
                                                          input vfdsu_pkg::fmt_t f);
    vfdsu_pkg::round_add_t r;
    int                    lo;
    int                    pos;
    lo  = 52 - frac_w(f);
    pos = lo + (emin_of(f) - int'(e));
    r   = '0;
    if (pos >= lo && pos <= 52)
      r[pos] = 1'b1;
    return r;
  endfunction

  // ========================================================
  // Reporting
  // ========================================================
  task automatic report_mismatch(input string tname, input string what,
                                 input logic [191:0] exp_v, input logic [191:0] act_v);
    errors++;
    $display("mismatch in %s: %s expected %0h actual %0h", tname, what, exp_v, act_v);
  endtask

  task automatic finish_run();
    $display("vectors %0d, errors %0d", vectors, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  endtask

  `include "tb_vfdsu_tasks.svh"

  initial
  begin
    ex2_pipe_clk = 1'b0;
    cpurst_b     = 1'b0;
    pipedown     = 1'b0;
    expnt_add0   = '0;
    expnt_add1   = '0;
    sqrt         = 1'b0;
    div          = 1'b0;
    double       = 1'b0;
    single       = 1'b0;
    op0_norm     = 1'b0;
    op1_norm     = 1'b0;
    result_inf   = 1'b0;
    of_rm_lfn    = 1'b0;
    srt_skip     = 1'b0;
    result_zero  = 1'b0;
    result_qnan  = 1'b0;
    nv           = 1'b0;
    dz           = 1'b0;
    result_sign  = 1'b0;
    qnan_sign    = 1'b0;
    qnan_f       = '0;
    rm           = '0;
    repeat (2) @(posedge ex2_pipe_clk);
    cpurst_b <= 1'b1;
    test_exponent();
    test_overflow();
    test_underflow();
    test_denorm();
    test_hold_reset();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+bench
src/vfdsu_pkg.sv
src/vfdsu_if.sv
src/vfdsu_expnt_calc.sv
src/vfdsu_expnt_range.sv
src/vfdsu_denorm_round_table.sv
src/vfdsu_ex3_pipe.sv
src/vfdsu_ex2_stage.sv
bench/tb_vfdsu_ex2_stage.sv

// ==== Makefile ====
# Verilator build and run for the VFDSU EX2 stage testbench

VERILATOR ?= verilator
TOP       ?= tb_vfdsu_ex2_stage
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(wildcard src/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
